/* spiBridgePkg.sv */
/* spi register bridge shared definitions
   word sizes, id constant, opcode and phase enums, address and write structs */
`default_nettype none

package spiBridgePkg;

	// register and spi word width
	localparam int dataWidth = 32;

	// register bank size and index width
	localparam int regCount = 16;
	localparam int regIndexWidth = 4;

	// constant returned by register 0
	localparam logic [dataWidth-1:0] idWord = 32'h5350_4252;

	// sck cycles per word, two words per frame
	localparam int wordBits = 32;
	localparam int frameBits = 2 * wordBits;

	// falling edge counter must hold 0 to frameBits
	localparam int fallCountWidth = $clog2(frameBits) + 1;

	// cycles from address capture to miso load
	localparam int readDelay = 6;

	// access direction, taken from address bit 30
	typedef enum logic
	{
		opRead = 1'b0,
		opWrite = 1'b1
	} csrOpE;

	// decoder frame state
	typedef enum logic [1:0]
	{
		phaseIdle = 2'd0,
		phaseAdrs = 2'd1,
		phaseData = 2'd2
	} decPhaseE;

	// first word of a frame, msb first on the wire
	typedef struct packed
	{
		logic reserved;
		csrOpE op;
		// must be zero for a valid access
		logic [25:0] upper;
		logic [regIndexWidth-1:0] index;
	} spiAdrsWordT;

	// write strobe from decoder to register bank
	typedef struct packed
	{
		logic valid;
		spiAdrsWordT adrs;
		logic [dataWidth-1:0] data;
	} csrWriteT;

endpackage

`default_nettype wire

/* spiSlaveDecoder.sv */
/* spi mode 0 slave decoder, oversampled by the system clock
   collects address and data words, issues register writes, shifts read data to miso */
`default_nettype none

module spiSlaveDecoder (
	input logic iSCLK,
	input logic rstN,
	input logic decEnable,
	input logic spiSck,
	input logic spiMosi,
	input logic spiCs,
	output logic spiMiso,
	input logic [spiBridgePkg::dataWidth-1:0] readData,
	output spiBridgePkg::spiAdrsWordT readAdrs,
	output spiBridgePkg::csrWriteT csrWrite
);
	import spiBridgePkg::*;

	// pin samplers, bit 2 is the oldest sample
	logic [2:0] sckSft;
	logic [2:0] mosiSft;
	logic [2:0] csSft;

	// edge strobes, only inside a frame
	logic csLow;
	logic sckRise;
	logic sckFall;

	// frame control
	decPhaseE phase;
	logic [fallCountWidth-1:0] fallCount;
	logic adrsDone;
	logic frameDone;

	// mosi collector and captured words
	logic [dataWidth-1:0] shiftIn;
	spiAdrsWordT adrsWord;
	logic writeValid;
	logic [dataWidth-1:0] writeData;

	// read side
	logic [readDelay-1:0] loadPipe;
	logic [dataWidth-1:0] misoSft;

	// decEnable low parks all three samplers at idle levels
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			sckSft <= 3'b000;
			mosiSft <= 3'b000;
			csSft <= 3'b111;
		end
		else if (!decEnable)
		begin
			sckSft <= 3'b000;
			mosiSft <= 3'b000;
			csSft <= 3'b111;
		end
		else
		begin
			sckSft <= {sckSft[1:0], spiSck};
			mosiSft <= {mosiSft[1:0], spiMosi};
			csSft <= {csSft[1:0], spiCs};
		end
	end

	assign csLow = ~csSft[2];
	assign sckRise = csLow && (sckSft[2:1] == 2'b01);
	assign sckFall = csLow && (sckSft[2:1] == 2'b10);

	// 32nd and 64th falling edge of the frame
	assign adrsDone = sckFall && (phase == phaseAdrs)
		&& (fallCount == fallCountWidth'(wordBits - 1));
	assign frameDone = sckFall && (phase == phaseData)
		&& (fallCount == fallCountWidth'(frameBits - 1));

	// mode 0, master data is stable around the rising edge
	always_ff @(posedge iSCLK)
	begin
		if (sckRise)
			shiftIn <= {shiftIn[dataWidth-2:0], mosiSft[2]};
		if (frameDone)
			writeData <= shiftIn;
	end

	// chip select high drops the frame at any point
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			phase <= phaseIdle;
			fallCount <= '0;
			adrsWord <= '0;
			writeValid <= 1'b0;
			loadPipe <= '0;
		end
		else if (!csLow)
		begin
			phase <= phaseIdle;
			fallCount <= '0;
			adrsWord <= '0;
			writeValid <= 1'b0;
			loadPipe <= '0;
		end
		else
		begin
			if (sckFall)
				fallCount <= fallCount + 1'b1;
			case (phase)
				phaseIdle: phase <= phaseAdrs;
				phaseAdrs:
				begin
					if (adrsDone)
						phase <= phaseData;
				end
				phaseData: phase <= phaseData;
				default: phase <= phaseIdle;
			endcase
			if (adrsDone)
				adrsWord <= spiAdrsWordT'(shiftIn);
			// single cycle write strobe, reads issue nothing
			writeValid <= frameDone && (adrsWord.op == opWrite);
			// gives the bank time to settle its registered read port
			loadPipe <= {loadPipe[readDelay-2:0], adrsDone};
		end
	end

	// miso loads once per frame, then fills with ones
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
			misoSft <= '0;
		else if (!csLow)
			misoSft <= '0;
		else if (loadPipe[readDelay-1])
			misoSft <= readData;
		else if (sckFall)
			misoSft <= {misoSft[dataWidth-2:0], 1'b1};
	end

	assign spiMiso = misoSft[dataWidth-1];
	assign readAdrs = adrsWord;
	assign csrWrite = '{valid: writeValid, adrs: adrsWord, data: writeData};

	// a write strobe belongs to a frame still in progress
	writeInFrame: assert property (@(posedge iSCLK) disable iff (!rstN)
		csrWrite.valid |-> csLow)
		else $error("csrWrite.valid with chip select high");

	// master gives exactly 64 sck cycles per frame
	fallLimit: assert property (@(posedge iSCLK) disable iff (!rstN)
		fallCount <= fallCountWidth'(frameBits))
		else $error("more than %0d falling sck edges in a frame", frameBits);

endmodule

`default_nettype wire

/* csrRegisterBank.sv */
/* control register bank, sixteen words with a read-only id at index 0
   writes from the spi decoder, registered read port */
`default_nettype none

module csrRegisterBank (
	input logic iSCLK,
	input logic rstN,
	input spiBridgePkg::csrWriteT csrWrite,
	input spiBridgePkg::spiAdrsWordT readAdrs,
	output logic [spiBridgePkg::dataWidth-1:0] readData,
	output logic [spiBridgePkg::dataWidth-1:0] ctrlWord
);
	import spiBridgePkg::*;

	// index 0 has no storage
	logic [dataWidth-1:0] regFile [1:regCount-1];

	// address checks
	logic writeInRange;
	logic writeHit;
	logic readInRange;

	// upper bits nonzero means outside the bank
	assign writeInRange = (csrWrite.adrs.upper == '0);
	assign readInRange = (readAdrs.upper == '0);

	// id register swallows writes
	assign writeHit = csrWrite.valid && (csrWrite.adrs.op == opWrite)
		&& writeInRange && (csrWrite.adrs.index != '0);

	// registers 1 to 15, cleared on reset
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 1; i < regCount; i++)
				regFile[i] <= '0;
		end
		else if (writeHit)
		begin
			regFile[csrWrite.adrs.index] <= csrWrite.data;
		end
	end

	// one cycle behind readAdrs
	always_ff @(posedge iSCLK)
	begin
		if (!readInRange)
			readData <= '0;
		else if (readAdrs.index == '0)
			readData <= idWord;
		else
			readData <= regFile[readAdrs.index];
	end

	// register 1 leaves the chip
	assign ctrlWord = regFile[1];

	// ctrlWord moves only on a decoded write to index 1
	ctrlWriteOnly: assert property (@(posedge iSCLK) disable iff (!rstN)
		$changed(regFile[1]) |-> $past(csrWrite.valid
			&& (csrWrite.adrs.index == regIndexWidth'(1))
			&& (csrWrite.adrs.upper == '0)))
		else $error("register 1 changed without a write, now %h", regFile[1]);

endmodule

`default_nettype wire

/* spiBridgeTop.sv */
/* spi register bridge top, decoder plus control register bank
   register 1 is exported as ctrlWord */
`default_nettype none

module spiBridgeTop (
	input logic iSCLK,
	input logic rstN,
	input logic decEnable,
	input logic spiSck,
	input logic spiMosi,
	input logic spiCs,
	output logic spiMiso,
	output logic [spiBridgePkg::dataWidth-1:0] ctrlWord
);
	import spiBridgePkg::*;

	// decoder to bank
	csrWriteT csrWrite;
	spiAdrsWordT readAdrs;

	// bank to decoder
	logic [dataWidth-1:0] readData;

	// pin side, frame decode and miso shifter
	spiSlaveDecoder spiSlaveDecoder_i (
		.iSCLK(iSCLK),
		.rstN(rstN),
		.decEnable(decEnable),
		.spiSck(spiSck),
		.spiMosi(spiMosi),
		.spiCs(spiCs),
		.spiMiso(spiMiso),
		.readData(readData),
		.readAdrs(readAdrs),
		.csrWrite(csrWrite)
	);

	// register storage and address checks
	csrRegisterBank csrRegisterBank_i (
		.iSCLK(iSCLK),
		.rstN(rstN),
		.csrWrite(csrWrite),
		.readAdrs(readAdrs),
		.readData(readData),
		.ctrlWord(ctrlWord)
	);

endmodule

`default_nettype wire

/* tbClockGen.sv */
/* testbench clock source
   free running square wave for the system clock */
`default_nettype none

module tbClockGen #(
	parameter int period = 8
) (
	output logic iSCLK
);

	// starts low, first rising edge half a period in
	initial
	begin
		iSCLK = 1'b0;
		forever
			#(period / 2) iSCLK = ~iSCLK;
	end

endmodule

`default_nettype wire

/* spiBridgeTb.sv */
/* spi register bridge testbench
   mode 0 master frames against a reference register model */
`default_nettype none

module spiBridgeTb;
	import spiBridgePkg::*;

	// sck half period in system clocks
	localparam int halfPeriod = 16;
	// inputs change this long after the rising clock edge
	localparam int driveDelay = 2;
	// frames issued by all tests, budget per frame
	localparam int frameBudget = 94;
	localparam int cyclesPerFrame = 2300;
	localparam int maxCycles = frameBudget * cyclesPerFrame;

	logic iSCLK;
	logic rstN;
	logic decEnable;
	logic spiSck;
	logic spiMosi;
	logic spiCs;
	logic spiMiso;
	logic [dataWidth-1:0] ctrlWord;

	// reference registers, index 0 unused
	logic [dataWidth-1:0] refRegs [0:regCount-1];
	logic [31:0] rngState;
	int errorCount;
	int checkCount;
	int cycleCount;

	// ctrlWord check strobe and its expected value
	logic ctrlCheck;
	logic [dataWidth-1:0] expCtrl;

	tbClockGen #(.period(8)) tbClockGen_i (.iSCLK(iSCLK));

	spiBridgeTop spiBridgeTop_i (
		.iSCLK(iSCLK),
		.rstN(rstN),
		.decEnable(decEnable),
		.spiSck(spiSck),
		.spiMosi(spiMosi),
		.spiCs(spiCs),
		.spiMiso(spiMiso),
		.ctrlWord(ctrlWord)
	);

	// exported control word against the model
	ctrlMatch: assert property (@(posedge iSCLK) disable iff (!rstN)
		ctrlCheck |-> (ctrlWord === expCtrl))
		else
		begin
			errorCount++;
			$display("[ERROR] ctrlWord expected %h got %h", expCtrl, ctrlWord);
		end

	// xorshift32 step
	function automatic logic [31:0] xorshift(input logic [31:0] seed);
		logic [31:0] x;
		x = seed;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// random register index 1 to 15
	function automatic logic [3:0] randomIndex();
		return 4'((nextRandom() % 32'd15) + 32'd1);
	endfunction

	// bit 31 reserved, bit 30 write flag, bits 3..0 index
	function automatic logic [31:0] makeAdrs(input logic wr, input logic [25:0] upper,
		input logic [3:0] index);
		return {1'b0, wr, upper, index};
	endfunction

	// reads outside the bank give zero, index 0 the id
	function automatic logic [31:0] modelRead(input logic [31:0] adrs);
		if (adrs[29:4] != 26'd0)
			return 32'd0;
		if (adrs[3:0] == 4'd0)
			return idWord;
		return refRegs[adrs[3:0]];
	endfunction

	function automatic void modelWrite(input logic [31:0] adrs, input logic [31:0] data);
		if (adrs[30] && (adrs[29:4] == 26'd0) && (adrs[3:0] != 4'd0))
			refRegs[adrs[3:0]] = data;
	endfunction

	task automatic nextCycles(input int count);
		repeat (count) @(posedge iSCLK);
		#driveDelay;
	endtask

	// runs bitCount sck cycles of a frame, then releases chip select
	task automatic shiftFrame(input logic [31:0] adrs, input logic [31:0] data,
		input int bitCount, output logic [31:0] readWord);
		logic [63:0] frame;
		frame = {adrs, data};
		readWord = '0;
		spiCs = 1'b0;
		for (int b = 0; b < bitCount; b++)
		begin
			// mosi settles a half period ahead of the rising edge
			spiMosi = frame[63 - b];
			nextCycles(halfPeriod);
			spiSck = 1'b1;
			if (b >= wordBits)
				readWord = {readWord[30:0], spiMiso};
			nextCycles(halfPeriod);
			spiSck = 1'b0;
		end
		nextCycles(halfPeriod);
		spiCs = 1'b1;
		spiMosi = 1'b0;
		// ctrlWord sampled ten cycles after the frame
		nextCycles(10);
		expCtrl = refRegs[1];
		ctrlCheck = 1'b1;
		checkCount++;
		nextCycles(1);
		ctrlCheck = 1'b0;
		nextCycles(4);
	endtask

	// complete 64 bit frame, read word checked on reads
	task automatic fullFrame(input logic [31:0] adrs, input logic [31:0] data);
		logic [31:0] readWord;
		logic [31:0] expRead;
		expRead = modelRead(adrs);
		if (decEnable)
			modelWrite(adrs, data);
		shiftFrame(adrs, data, frameBits, readWord);
		if (!adrs[30] && decEnable)
		begin
			checkCount++;
			assert (readWord === expRead)
			else
			begin
				errorCount++;
				$display("[ERROR] spiMiso read of %h expected %h got %h",
					adrs, expRead, readWord);
			end
		end
	endtask

	// chip select rises early, model stays as it is
	task automatic abortFrame(input logic [31:0] adrs, input logic [31:0] data,
		input int bitCount);
		logic [31:0] unused;
		shiftFrame(adrs, data, bitCount, unused);
	endtask

	// run limit
	always @(posedge iSCLK)
	begin
		cycleCount++;
		if (cycleCount >= maxCycles)
		begin
			$display("timeout after %0d cycles, a frame never finished", cycleCount);
			$display("Test failed");
			$finish;
		end
	end

	initial
	begin
		logic [31:0] value;
		logic [3:0] idx;
		rstN = 1'b0;
		decEnable = 1'b1;
		spiSck = 1'b0;
		spiMosi = 1'b0;
		spiCs = 1'b1;
		ctrlCheck = 1'b0;
		expCtrl = '0;
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		rngState = 32'hbcae_093a;
		for (int i = 0; i < regCount; i++)
			refRegs[i] = '0;
		nextCycles(4);
		rstN = 1'b1;
		nextCycles(4);

		// register 1 drives ctrlWord and reads back
		value = nextRandom();
		fullFrame(makeAdrs(1'b1, 26'd0, 4'd1), value);
		fullFrame(makeAdrs(1'b0, 26'd0, 4'd1), 32'd0);

		// random write then read
		for (int n = 0; n < 40; n++)
		begin
			idx = randomIndex();
			value = nextRandom();
			fullFrame(makeAdrs(1'b1, 26'd0, idx), value);
			fullFrame(makeAdrs(1'b0, 26'd0, idx), 32'd0);
		end

		// id register ignores writes
		fullFrame(makeAdrs(1'b0, 26'd0, 4'd0), 32'd0);
		fullFrame(makeAdrs(1'b1, 26'd0, 4'd0), nextRandom());
		fullFrame(makeAdrs(1'b0, 26'd0, 4'd0), 32'd0);

		// frame cut after 40 bits, then a normal write and read
		idx = randomIndex();
		abortFrame(makeAdrs(1'b1, 26'd0, idx), nextRandom(), 40);
		fullFrame(makeAdrs(1'b0, 26'd0, idx), 32'd0);
		fullFrame(makeAdrs(1'b1, 26'd0, idx), nextRandom());
		fullFrame(makeAdrs(1'b0, 26'd0, idx), 32'd0);

		// decoder disabled, the write goes nowhere
		decEnable = 1'b0;
		fullFrame(makeAdrs(1'b1, 26'd0, 4'd1), nextRandom());
		decEnable = 1'b1;
		nextCycles(4);
		fullFrame(makeAdrs(1'b0, 26'd0, 4'd1), 32'd0);

		// nonzero upper bits, out of range both ways
		fullFrame(makeAdrs(1'b1, 26'h0000_100, 4'd1), nextRandom());
		fullFrame(makeAdrs(1'b0, 26'h0200_000, 4'd1), 32'd0);
		fullFrame(makeAdrs(1'b0, 26'd0, 4'd1), 32'd0);

		nextCycles(4);
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
spiBridgePkg.sv
spiSlaveDecoder.sv
csrRegisterBank.sv
spiBridgeTop.sv
tbClockGen.sv
spiBridgeTb.sv

/* Makefile */
# Verilator build and run of the spi register bridge testbench

SIM      = verilator
FLAGS    = --binary --assert --timing -j 0
TOP      = spiBridgeTb
FILELIST = build.f
OBJDIR   = obj_dir
SIMBIN   = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIMBIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the log decides pass or fail
run: $(SIMBIN)
	./$(SIMBIN) | tee $(LOG)
	@grep -qx 'Test passed' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
